// File: verilog/cipher_ctrl_pkg.sv
package cipher_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // Sparse two-value flags
  ////////////////////////////////////////////////////////////

  // One rail per bit of a sparse flag
  localparam int unsigned Sp2VWidth = 3;

  typedef enum logic [Sp2VWidth-1:0] {
    SP2V_HIGH = 3'b011,
    SP2V_LOW  = 3'b100
  } sp2v_e;

  // Bit i set means rail i is active high
  localparam logic [Sp2VWidth-1:0] Sp2VHighBits = 3'b011;

  ////////////////////////////////////////////////////////////
  // Cipher configuration
  ////////////////////////////////////////////////////////////

  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

  typedef enum logic [1:0] {
    AES_128 = 2'b00,
    AES_192 = 2'b01,
    AES_256 = 2'b10  // 2'b11 is illegal
  } key_len_e;

  localparam int unsigned RoundCtrWidth = 4;

  localparam logic [RoundCtrWidth-1:0] NumRounds128 = 4'd10;
  localparam logic [RoundCtrWidth-1:0] NumRounds192 = 4'd12;
  localparam logic [RoundCtrWidth-1:0] NumRounds256 = 4'd14;

  // Add-round-key source, one-hot
  typedef enum logic [2:0] {
    ADD_RK_INIT  = 3'b001,
    ADD_RK_ROUND = 3'b010,
    ADD_RK_FINAL = 3'b100
  } add_rk_sel_e;

  // Selector outputs of one rail
  typedef struct packed {
    add_rk_sel_e add_rk_sel;
    ciph_op_e    key_expand_op;
  } rail_sel_t;

endpackage

// File: verilog/cipher_ctrl_if.sv
// Decoded request bits fanned out to all rails
interface rail_in_if;
  logic [cipher_ctrl_pkg::Sp2VWidth-1:0] in_valid;     // Bit i feeds rail i
  logic [cipher_ctrl_pkg::Sp2VWidth-1:0] out_ready;
  logic [cipher_ctrl_pkg::Sp2VWidth-1:0] dec_key_gen;
  cipher_ctrl_pkg::ciph_op_e             op;
  cipher_ctrl_pkg::key_len_e             key_len;

  modport src (output in_valid, out_ready, dec_key_gen, op, key_len);
  modport dst (input  in_valid, out_ready, dec_key_gen, op, key_len);
endinterface

// Outputs of one rail
// Single-bit flags use the rail's polarity while round and sel are true values
interface rail_out_if;
  logic                                      in_ready;
  logic                                      out_valid;
  logic                                      state_we;
  logic [cipher_ctrl_pkg::RoundCtrWidth-1:0] round;
  cipher_ctrl_pkg::rail_sel_t                sel;

  modport rail (output in_ready, out_valid, state_we, round, sel);
  modport comb (input  in_ready, out_valid, state_we, round, sel);
endinterface

// File: verilog/sp2v_decode.sv
module sp2v_decode (
  input  cipher_ctrl_pkg::sp2v_e    in_valid_i,
  input  cipher_ctrl_pkg::sp2v_e    out_ready_i,
  input  cipher_ctrl_pkg::sp2v_e    dec_key_gen_i,
  input  cipher_ctrl_pkg::ciph_op_e op_i,
  input  cipher_ctrl_pkg::key_len_e key_len_i,
  rail_in_if.src                    rail,
  output logic                      enc_err_o
);

  logic in_valid_err;
  logic out_ready_err;
  logic dec_key_gen_err;
  logic key_len_err;

  ////////////////////////////////////////////////////////////
  // Encoding checks
  ////////////////////////////////////////////////////////////

  assign in_valid_err = !(in_valid_i inside {cipher_ctrl_pkg::SP2V_HIGH,
                                             cipher_ctrl_pkg::SP2V_LOW});
  assign out_ready_err = !(out_ready_i inside {cipher_ctrl_pkg::SP2V_HIGH,
                                               cipher_ctrl_pkg::SP2V_LOW});
  assign dec_key_gen_err = !(dec_key_gen_i inside {cipher_ctrl_pkg::SP2V_HIGH,
                                                   cipher_ctrl_pkg::SP2V_LOW});

  // 2'b11 has no round count
  assign key_len_err = !(key_len_i inside {cipher_ctrl_pkg::AES_128,
                                           cipher_ctrl_pkg::AES_192,
                                           cipher_ctrl_pkg::AES_256});

  assign enc_err_o = in_valid_err | out_ready_err | dec_key_gen_err | key_len_err;

  ////////////////////////////////////////////////////////////
  // Fan-out to the rails
  ////////////////////////////////////////////////////////////

  // Raw bits, each rail interprets its own bit
  assign rail.in_valid    = in_valid_i;
  assign rail.out_ready   = out_ready_i;
  assign rail.dec_key_gen = dec_key_gen_i;
  assign rail.op          = op_i;
  assign rail.key_len     = key_len_i;

endmodule

// File: verilog/round_rail_fsm.sv
module round_rail_fsm #(
  parameter bit          Polarity = 1'b1,  // 1 means active high
  parameter int unsigned RailIdx  = 0
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  rail_in_if.dst   bit_i,
  input  logic     fatal_i,
  rail_out_if.rail out
);

  typedef enum logic [2:0] {
    IDLE,
    INIT,
    ROUND,
    FINISH,
    ERROR
  } state_e;

  state_e                                    state_q, state_d;
  logic [cipher_ctrl_pkg::RoundCtrWidth-1:0] round_q;
  logic [cipher_ctrl_pkg::RoundCtrWidth-1:0] nr_q, nr_sel;
  cipher_ctrl_pkg::ciph_op_e                 op_q;
  logic                                      dec_key_gen_q;

  logic in_valid, out_ready, dec_key_gen;  // True polarity
  logic in_ready, out_valid, state_we;
  logic accept;
  logic last_round;

  assign in_valid    = (bit_i.in_valid[RailIdx] == Polarity);
  assign out_ready   = (bit_i.out_ready[RailIdx] == Polarity);
  assign dec_key_gen = (bit_i.dec_key_gen[RailIdx] == Polarity);

  assign accept     = (state_q == IDLE) && in_valid;
  assign last_round = (round_q == nr_q);

  // Rounds per key length
  always_comb begin : sel_num_rounds
    unique case (bit_i.key_len)
      cipher_ctrl_pkg::AES_192: nr_sel = cipher_ctrl_pkg::NumRounds192;
      cipher_ctrl_pkg::AES_256: nr_sel = cipher_ctrl_pkg::NumRounds256;
      default:                  nr_sel = cipher_ctrl_pkg::NumRounds128;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////

  always_comb begin : next_state
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (in_valid) state_d = INIT;
      INIT:    state_d = ROUND;
      ROUND:   if (last_round) state_d = FINISH;
      FINISH:  if (out_ready) state_d = IDLE;
      ERROR:   state_d = ERROR;  // Terminal until reset
      default: state_d = ERROR;
    endcase
    if (fatal_i) begin
      state_d = ERROR;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : regs
    if (!rst_ni) begin
      state_q       <= IDLE;
      round_q       <= '0;
      nr_q          <= cipher_ctrl_pkg::NumRounds128;
      op_q          <= cipher_ctrl_pkg::CIPH_FWD;
      dec_key_gen_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        round_q       <= '0;
        nr_q          <= nr_sel;
        op_q          <= bit_i.op;
        dec_key_gen_q <= dec_key_gen;
      end else if (state_q == INIT || (state_q == ROUND && !last_round)) begin
        round_q <= round_q + 1'b1;
      end
    end
  end

  assign in_ready  = (state_q == IDLE);
  assign out_valid = (state_q == FINISH);
  // No state update while only the decryption key is generated
  assign state_we  = (state_q inside {INIT, ROUND}) && !dec_key_gen_q;

  // Back to rail polarity
  assign out.in_ready  = in_ready ~^ Polarity;
  assign out.out_valid = out_valid ~^ Polarity;
  assign out.state_we  = state_we ~^ Polarity;
  assign out.round     = round_q;

  always_comb begin : selectors
    out.sel.add_rk_sel = cipher_ctrl_pkg::ADD_RK_ROUND;
    if (state_q == INIT) begin
      out.sel.add_rk_sel = cipher_ctrl_pkg::ADD_RK_INIT;
    end else if (state_q == ROUND && last_round) begin
      out.sel.add_rk_sel = cipher_ctrl_pkg::ADD_RK_FINAL;
    end
    out.sel.key_expand_op = dec_key_gen_q ? cipher_ctrl_pkg::CIPH_FWD : op_q;
  end

endmodule

// File: verilog/rail_combine.sv
module rail_combine #(
  parameter type payload_t = logic
) (
  input  payload_t rails_i [cipher_ctrl_pkg::Sp2VWidth],
  output payload_t comb_o,
  output logic     mismatch_o
);

  // One rail is enough to set a bit
  always_comb begin : or_rails
    comb_o = '0;
    for (int i = 0; i < cipher_ctrl_pkg::Sp2VWidth; i++) begin
      comb_o = payload_t'(comb_o | rails_i[i]);
    end
  end

  // Any rail off the OR result is a disagreement
  always_comb begin : check_rails
    mismatch_o = 1'b0;
    for (int i = 0; i < cipher_ctrl_pkg::Sp2VWidth; i++) begin
      if (rails_i[i] != comb_o) begin
        mismatch_o = 1'b1;
      end
    end
  end

endmodule

// File: verilog/cipher_result.sv
module cipher_result (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  rail_out_if.comb                                  rails [cipher_ctrl_pkg::Sp2VWidth],
  input  logic                                      enc_err_i,
  output logic                                      fatal_o,
  output cipher_ctrl_pkg::sp2v_e                    in_ready_o,
  output cipher_ctrl_pkg::sp2v_e                    out_valid_o,
  output logic                                      state_we_o,
  output logic [cipher_ctrl_pkg::RoundCtrWidth-1:0] round_o,
  output cipher_ctrl_pkg::add_rk_sel_e              add_rk_sel_o,
  output cipher_ctrl_pkg::ciph_op_e                 key_expand_op_o,
  output logic                                      alert_o
);

  logic [cipher_ctrl_pkg::Sp2VWidth-1:0]     in_ready_mr, out_valid_mr, state_we_mr;
  cipher_ctrl_pkg::rail_sel_t                sel_mr [cipher_ctrl_pkg::Sp2VWidth];
  logic [cipher_ctrl_pkg::RoundCtrWidth-1:0] round_mr [cipher_ctrl_pkg::Sp2VWidth];
  cipher_ctrl_pkg::rail_sel_t                sel;
  logic                                      sel_err, round_err, flag_err;
  logic                                      alert_q;

  // Restore true polarity per rail
  for (genvar i = 0; i < cipher_ctrl_pkg::Sp2VWidth; i++) begin : gen_rail
    assign in_ready_mr[i]  = rails[i].in_ready ~^ cipher_ctrl_pkg::Sp2VHighBits[i];
    assign out_valid_mr[i] = rails[i].out_valid ~^ cipher_ctrl_pkg::Sp2VHighBits[i];
    assign state_we_mr[i]  = rails[i].state_we ~^ cipher_ctrl_pkg::Sp2VHighBits[i];
    assign sel_mr[i]       = rails[i].sel;
    assign round_mr[i]     = rails[i].round;
  end

  rail_combine #(
    .payload_t ( cipher_ctrl_pkg::rail_sel_t )
  ) u_sel_comb (
    .rails_i    ( sel_mr  ),
    .comb_o     ( sel     ),
    .mismatch_o ( sel_err )
  );

  rail_combine #(
    .payload_t ( logic [cipher_ctrl_pkg::RoundCtrWidth-1:0] )
  ) u_round_comb (
    .rails_i    ( round_mr  ),
    .comb_o     ( round_o   ),
    .mismatch_o ( round_err )
  );

  // Flags must be all set or all clear
  assign flag_err = (|in_ready_mr  && !(&in_ready_mr))  ||
                    (|out_valid_mr && !(&out_valid_mr)) ||
                    (|state_we_mr  && !(&state_we_mr));

  ////////////////////////////////////////////////////////////
  // Sticky alert
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : reg_alert
    if (!rst_ni) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= alert_q | enc_err_i | sel_err | round_err | flag_err;
    end
  end

  assign fatal_o = alert_q;
  assign alert_o = alert_q;

  // Handshake is blocked as soon as the alert is set
  assign in_ready_o  = (&in_ready_mr && !alert_q) ? cipher_ctrl_pkg::SP2V_HIGH
                                                   : cipher_ctrl_pkg::SP2V_LOW;
  assign out_valid_o = (&out_valid_mr && !alert_q) ? cipher_ctrl_pkg::SP2V_HIGH
                                                    : cipher_ctrl_pkg::SP2V_LOW;

  assign state_we_o      = &state_we_mr;
  assign add_rk_sel_o    = sel.add_rk_sel;
  assign key_expand_op_o = sel.key_expand_op;

endmodule

// File: verilog/cipher_ctrl_top.sv
module cipher_ctrl_top (
  input  logic                                      clk_i,
  input  logic                                      rst_ni,
  // Request handshake
  input  cipher_ctrl_pkg::sp2v_e                    in_valid_i,
  output cipher_ctrl_pkg::sp2v_e                    in_ready_o,
  input  cipher_ctrl_pkg::ciph_op_e                 op_i,
  input  cipher_ctrl_pkg::key_len_e                 key_len_i,
  input  cipher_ctrl_pkg::sp2v_e                    dec_key_gen_i,
  // Result handshake
  output cipher_ctrl_pkg::sp2v_e                    out_valid_o,
  input  cipher_ctrl_pkg::sp2v_e                    out_ready_i,
  // Datapath control
  output logic                                      state_we_o,
  output logic [cipher_ctrl_pkg::RoundCtrWidth-1:0] round_o,
  output cipher_ctrl_pkg::add_rk_sel_e              add_rk_sel_o,
  output cipher_ctrl_pkg::ciph_op_e                 key_expand_op_o,
  output logic                                      alert_o
);

  logic enc_err;
  logic fatal;

  rail_in_if  u_rail_in ();
  rail_out_if u_rail_out [cipher_ctrl_pkg::Sp2VWidth] ();

  sp2v_decode u_decode (
    .in_valid_i    ( in_valid_i    ),
    .out_ready_i   ( out_ready_i   ),
    .dec_key_gen_i ( dec_key_gen_i ),
    .op_i          ( op_i          ),
    .key_len_i     ( key_len_i     ),
    .rail          ( u_rail_in     ),
    .enc_err_o     ( enc_err       )
  );

  ////////////////////////////////////////////////////////////
  // Redundant rails
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < cipher_ctrl_pkg::Sp2VWidth; i++) begin : gen_rail
    round_rail_fsm #(
      .Polarity ( cipher_ctrl_pkg::Sp2VHighBits[i] ),
      .RailIdx  ( i                                )
    ) u_rail (
      .clk_i   ( clk_i         ),
      .rst_ni  ( rst_ni        ),
      .bit_i   ( u_rail_in     ),
      .fatal_i ( fatal         ),
      .out     ( u_rail_out[i] )
    );
  end

  cipher_result u_result (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .rails           ( u_rail_out      ),
    .enc_err_i       ( enc_err         ),
    .fatal_o         ( fatal           ),
    .in_ready_o      ( in_ready_o      ),
    .out_valid_o     ( out_valid_o     ),
    .state_we_o      ( state_we_o      ),
    .round_o         ( round_o         ),
    .add_rk_sel_o    ( add_rk_sel_o    ),
    .key_expand_op_o ( key_expand_op_o ),
    .alert_o         ( alert_o         )
  );

endmodule

// File: verif/tb_clk_gen.sv
module tb_clk_gen (
  input  logic rst_req_i,
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HalfPeriod  = 4;  // 8 ns clock
  localparam int ResetCycles = 16;

  initial begin : gen_clk
    clk_o = 1'b0;
    forever begin
      #HalfPeriod clk_o = ~clk_o;
    end
  end

  // Reset at start and again on every request
  initial begin : gen_rst
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1 rst_no = 1'b1;
    forever begin
      @(posedge rst_req_i);
      rst_no = 1'b0;
      repeat (ResetCycles) @(posedge clk_o);
      #1 rst_no = 1'b1;
    end
  end

endmodule

// File: verif/cipher_ctrl_checker.sv
module cipher_ctrl_checker (
  input logic                   clk_i,
  input logic                   rst_ni,
  input cipher_ctrl_pkg::sp2v_e in_ready_i,
  input cipher_ctrl_pkg::sp2v_e out_valid_i,
  input logic                   state_we_i,
  input logic                   alert_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Only a reset clears the alert
  alert_sticky: assert property (@(posedge clk_i) $fell(alert_i) |-> !rst_ni)
    else $error("alert_o fell while reset was inactive");

  // A waiting result blocks new requests
  valid_blocks_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid_i == cipher_ctrl_pkg::SP2V_HIGH) |-> (in_ready_i == cipher_ctrl_pkg::SP2V_LOW))
    else $error("in_ready_o is not LOW while out_valid_o is HIGH");

  // Result waiting, datapath must hold
  no_we_on_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (out_valid_i == cipher_ctrl_pkg::SP2V_HIGH) |-> !state_we_i)
    else $error("state_we_o set while out_valid_o is HIGH");

endmodule

// File: verif/tb_cipher_ctrl.sv
module tb_cipher_ctrl;

  timeunit 1ns;
  timeprecision 100ps;

  typedef logic [cipher_ctrl_pkg::RoundCtrWidth-1:0] round_t;

  localparam int ClkPeriod        = 8;
  localparam int ResetCycles      = 16;
  localparam int NumRequests      = 9;
  localparam int CyclesPerRequest = 40;
  localparam int WaitLimit        = 40;  // Per handshake
  localparam int Timeout = (NumRequests * CyclesPerRequest + 2 * ResetCycles) * ClkPeriod;

  logic                         clk;
  logic                         rst_n;
  logic                         rst_req;
  cipher_ctrl_pkg::sp2v_e       in_valid, in_ready, out_valid, out_ready, dec_key_gen;
  cipher_ctrl_pkg::ciph_op_e    op, key_expand_op;
  cipher_ctrl_pkg::key_len_e    key_len;
  cipher_ctrl_pkg::add_rk_sel_e add_rk_sel;
  round_t                       round;
  logic                         state_we;
  logic                         alert;

  logic [31:0] lfsr_q = 32'h5527d8a9;
  int          num_tests, num_checks, num_errors;

  // Per-cycle controls from INIT up to the valid result
  logic                         trace_we[$];
  cipher_ctrl_pkg::add_rk_sel_e trace_sel[$];
  round_t                       trace_round[$];
  cipher_ctrl_pkg::ciph_op_e    trace_kop[$];

  tb_clk_gen u_clk_gen (
    .rst_req_i ( rst_req ),
    .clk_o     ( clk     ),
    .rst_no    ( rst_n   )
  );

  cipher_ctrl_top u_dut (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .in_valid_i      ( in_valid      ),
    .in_ready_o      ( in_ready      ),
    .op_i            ( op            ),
    .key_len_i       ( key_len       ),
    .dec_key_gen_i   ( dec_key_gen   ),
    .out_valid_o     ( out_valid     ),
    .out_ready_i     ( out_ready     ),
    .state_we_o      ( state_we      ),
    .round_o         ( round         ),
    .add_rk_sel_o    ( add_rk_sel    ),
    .key_expand_op_o ( key_expand_op ),
    .alert_o         ( alert         )
  );

  bind cipher_ctrl_top cipher_ctrl_checker u_checker (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .in_ready_i  ( in_ready_o  ),
    .out_valid_i ( out_valid_o ),
    .state_we_i  ( state_we_o  ),
    .alert_i     ( alert_o     )
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      val = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  function automatic cipher_ctrl_pkg::key_len_e random_key_len();
    return cipher_ctrl_pkg::key_len_e'(2'(rand_bits(2) % 3));
  endfunction

  function automatic cipher_ctrl_pkg::ciph_op_e random_op();
    logic [31:0] r;
    r = rand_bits(1);
    return cipher_ctrl_pkg::ciph_op_e'(r[0]);
  endfunction

  // AES round counts per key length
  function automatic int num_rounds(input cipher_ctrl_pkg::key_len_e kl);
    case (kl)
      cipher_ctrl_pkg::AES_192: return 12;
      cipher_ctrl_pkg::AES_256: return 14;
      default:                  return 10;
    endcase
  endfunction

  function automatic int count_we();
    int n;
    n = 0;
    foreach (trace_we[i]) begin
      n += int'(trace_we[i]);
    end
    return n;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;  // Outputs settled, inputs driven here
  endtask

  task automatic report_failure(input string msg);
    num_errors++;
    $display("[FAIL] %0t %s", $time, msg);
  endtask

  task automatic check_sp2v(input string name, input cipher_ctrl_pkg::sp2v_e got,
                            input cipher_ctrl_pkg::sp2v_e exp);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_op(input string name, input cipher_ctrl_pkg::ciph_op_e got,
                          input cipher_ctrl_pkg::ciph_op_e exp);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_rk_sel(input string name, input cipher_ctrl_pkg::add_rk_sel_e got,
                              input cipher_ctrl_pkg::add_rk_sel_e exp);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_round(input string name, input round_t got, input round_t exp);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    num_checks++;
    if (got !== exp) begin
      num_errors++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    num_checks++;
    if (got != exp) begin
      num_errors++;
      $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    num_tests++;
    $display("%-18s %s", name, (num_errors == errors_before) ? "ok" : "FAILED");
  endtask

  task automatic apply_reset();
    rst_req = 1'b1;
    wait (rst_n === 1'b0);
    rst_req = 1'b0;
    wait (rst_n === 1'b1);
    next_cycle();
  endtask

  // Latency counts edges from acceptance to a valid result, -1 if none
  task automatic send_request(input cipher_ctrl_pkg::ciph_op_e req_op,
                              input cipher_ctrl_pkg::key_len_e req_key_len,
                              input logic dkg, output int latency);
    int n;
    latency = -1;
    trace_we.delete();
    trace_sel.delete();
    trace_round.delete();
    trace_kop.delete();
    in_valid    = cipher_ctrl_pkg::SP2V_HIGH;
    op          = req_op;
    key_len     = req_key_len;
    dec_key_gen = dkg ? cipher_ctrl_pkg::SP2V_HIGH : cipher_ctrl_pkg::SP2V_LOW;
    n = 0;
    while (in_ready != cipher_ctrl_pkg::SP2V_HIGH && n < WaitLimit) begin
      next_cycle();
      n++;
    end
    if (in_ready != cipher_ctrl_pkg::SP2V_HIGH) begin
      in_valid = cipher_ctrl_pkg::SP2V_LOW;
      report_failure("request was not accepted in time");
      return;
    end
    next_cycle();  // Accepting edge
    in_valid = cipher_ctrl_pkg::SP2V_LOW;
    n = 0;
    while (out_valid != cipher_ctrl_pkg::SP2V_HIGH && n < WaitLimit) begin
      trace_we.push_back(state_we);
      trace_sel.push_back(add_rk_sel);
      trace_round.push_back(round);
      trace_kop.push_back(key_expand_op);
      next_cycle();
      n++;
    end
    if (out_valid != cipher_ctrl_pkg::SP2V_HIGH) begin
      report_failure("result never became valid");
    end else begin
      latency = n;
    end
  endtask

  // Holds out_ready LOW for some cycles, then completes the result handshake
  task automatic take_result(input int stall);
    for (int i = 0; i < stall; i++) begin
      check_sp2v("out_valid_o", out_valid, cipher_ctrl_pkg::SP2V_HIGH);
      check_sp2v("in_ready_o", in_ready, cipher_ctrl_pkg::SP2V_LOW);
      next_cycle();
    end
    check_sp2v("out_valid_o", out_valid, cipher_ctrl_pkg::SP2V_HIGH);
    out_ready = cipher_ctrl_pkg::SP2V_HIGH;
    next_cycle();
    out_ready = cipher_ctrl_pkg::SP2V_LOW;
    check_sp2v("out_valid_o", out_valid, cipher_ctrl_pkg::SP2V_LOW);
    check_sp2v("in_ready_o", in_ready, cipher_ctrl_pkg::SP2V_HIGH);
  endtask

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset_values();
    int err0;
    err0 = num_errors;
    check_sp2v("in_ready_o", in_ready, cipher_ctrl_pkg::SP2V_HIGH);
    check_sp2v("out_valid_o", out_valid, cipher_ctrl_pkg::SP2V_LOW);
    check_bit("state_we_o", state_we, 1'b0);
    check_bit("alert_o", alert, 1'b0);
    end_test("reset_values", err0);
  endtask

  task automatic test_round_counts();
    int                        err0, latency, nr;
    cipher_ctrl_pkg::key_len_e kl;
    err0 = num_errors;
    for (int k = 0; k < 3; k++) begin
      kl = cipher_ctrl_pkg::key_len_e'(2'(k));
      nr = num_rounds(kl);
      send_request(cipher_ctrl_pkg::CIPH_FWD, kl, 1'b0, latency);
      check_count("latency", latency, nr + 1);  // Init cycle plus Nr rounds
      check_count("state_we_o pulses", count_we(), nr + 1);
      check_round("round_o", round, round_t'(nr));
      take_result(0);
    end
    end_test("round_counts", err0);
  endtask

  task automatic test_key_expand();
    int                        err0, latency, nr;
    cipher_ctrl_pkg::key_len_e kl;
    err0 = num_errors;
    kl = random_key_len();
    nr = num_rounds(kl);
    send_request(cipher_ctrl_pkg::CIPH_INV, kl, 1'b0, latency);
    foreach (trace_kop[i]) begin
      check_op("key_expand_op_o", trace_kop[i], cipher_ctrl_pkg::CIPH_INV);
    end
    check_count("state_we_o pulses", count_we(), nr + 1);
    take_result(0);
    // Decryption key generation expands forward and leaves the state alone
    send_request(cipher_ctrl_pkg::CIPH_INV, kl, 1'b1, latency);
    foreach (trace_kop[i]) begin
      check_op("key_expand_op_o", trace_kop[i], cipher_ctrl_pkg::CIPH_FWD);
    end
    check_count("state_we_o pulses", count_we(), 0);
    take_result(0);
    end_test("key_expand", err0);
  endtask

  task automatic test_selectors();
    int                           err0, latency, nr;
    cipher_ctrl_pkg::key_len_e    kl;
    cipher_ctrl_pkg::add_rk_sel_e exp_sel;
    err0 = num_errors;
    kl = random_key_len();
    nr = num_rounds(kl);
    send_request(random_op(), kl, 1'b0, latency);
    check_count("selector cycles", trace_sel.size(), nr + 1);
    foreach (trace_sel[i]) begin
      exp_sel = (i == 0)  ? cipher_ctrl_pkg::ADD_RK_INIT  :
                (i == nr) ? cipher_ctrl_pkg::ADD_RK_FINAL : cipher_ctrl_pkg::ADD_RK_ROUND;
      check_rk_sel("add_rk_sel_o", trace_sel[i], exp_sel);
      check_round("round_o", trace_round[i], round_t'(i));
    end
    take_result(0);
    end_test("selectors", err0);
  endtask

  task automatic test_back_pressure();
    int                        err0, latency, stall;
    cipher_ctrl_pkg::key_len_e kl;
    err0 = num_errors;
    for (int k = 0; k < 2; k++) begin
      kl = random_key_len();
      stall = 1 + int'(rand_bits(3));
      send_request(random_op(), kl, 1'b0, latency);
      check_count("latency", latency, num_rounds(kl) + 1);
      take_result(stall);
    end
    end_test("back_pressure", err0);
  endtask

  task automatic test_invalid_encoding();
    int err0, latency;
    err0 = num_errors;
    in_valid = cipher_ctrl_pkg::sp2v_e'(3'b111);
    next_cycle();
    check_bit("alert_o", alert, 1'b1);
    // Legal requests are ignored from now on
    in_valid = cipher_ctrl_pkg::SP2V_HIGH;
    for (int i = 0; i < 20; i++) begin
      check_sp2v("in_ready_o", in_ready, cipher_ctrl_pkg::SP2V_LOW);
      check_sp2v("out_valid_o", out_valid, cipher_ctrl_pkg::SP2V_LOW);
      check_bit("alert_o", alert, 1'b1);
      next_cycle();
    end
    in_valid = cipher_ctrl_pkg::SP2V_LOW;
    apply_reset();
    check_bit("alert_o", alert, 1'b0);
    check_sp2v("in_ready_o", in_ready, cipher_ctrl_pkg::SP2V_HIGH);
    check_sp2v("out_valid_o", out_valid, cipher_ctrl_pkg::SP2V_LOW);
    send_request(cipher_ctrl_pkg::CIPH_FWD, cipher_ctrl_pkg::AES_128, 1'b0, latency);
    check_count("latency", latency, 11);
    take_result(0);
    end_test("invalid_encoding", err0);
  endtask

  ////////////////////////////////////////////////////////////
  // Run
  ////////////////////////////////////////////////////////////

  initial begin : watchdog
    #(Timeout);
    $display("Timeout at %0t, the tests did not finish", $time);
    $display("Regression failed");
    $finish;
  end

  initial begin : run_tests
    rst_req     = 1'b0;
    in_valid    = cipher_ctrl_pkg::SP2V_LOW;
    out_ready   = cipher_ctrl_pkg::SP2V_LOW;
    dec_key_gen = cipher_ctrl_pkg::SP2V_LOW;
    op          = cipher_ctrl_pkg::CIPH_FWD;
    key_len     = cipher_ctrl_pkg::AES_128;
    num_tests   = 0;
    num_checks  = 0;
    num_errors  = 0;
    wait (rst_n === 1'b1);
    next_cycle();
    test_reset_values();
    test_round_counts();
    test_key_expand();
    test_selectors();
    test_back_pressure();
    test_invalid_encoding();
    $display("%0d tests, %0d checks, %0d errors", num_tests, num_checks, num_errors);
    if (num_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: build.f
verilog/cipher_ctrl_pkg.sv
verilog/cipher_ctrl_if.sv
verilog/sp2v_decode.sv
verilog/round_rail_fsm.sv
verilog/rail_combine.sv
verilog/cipher_result.sv
verilog/cipher_ctrl_top.sv
verif/tb_clk_gen.sv
verif/cipher_ctrl_checker.sv
verif/tb_cipher_ctrl.sv

// File: Makefile
TOP := tb_cipher_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps -f build.f \
	  --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir
